// ==== common/csr_config.svh ====
`ifndef CSR_CONFIG_SVH
`define CSR_CONFIG_SVH

`define XLEN                  64
`define CSR_ADDR_W            12

// read-only machine information
`define CSR_MVENDORID         12'hf11
`define CSR_MARCHID           12'hf12
`define CSR_MIMPID            12'hf13
`define CSR_MHARTID           12'hf14

// trap setup
`define CSR_MSTATUS           12'h300
`define CSR_MISA              12'h301
`define CSR_MIE               12'h304
`define CSR_MTVEC             12'h305

// trap handling
`define CSR_MSCRATCH          12'h340
`define CSR_MEPC              12'h341
`define CSR_MCAUSE            12'h342
`define CSR_MTVAL             12'h343
`define CSR_MIP               12'h344

`define CSR_CYCLE             12'hc00
`define CSR_TIME              12'hc01
`define CSR_MTIMECMP          12'hbbf

`define CAUSE_MISALIGNED      63'd0
`define CAUSE_ILLEGAL_INSTR   63'd2
`define CAUSE_EBREAK          63'd3
`define CAUSE_LW_FAULT        63'd5
`define CAUSE_SW_FAULT        63'd7
`define CAUSE_ECALL           63'd11
`define CAUSE_M_TIMER         63'd7   // interrupt codes
`define CAUSE_M_EXTERNAL      63'd11

`define MISA_VALUE            64'h8000_0000_0010_1105   // rv64 with i m a c and u

`endif

// ==== common/csr_pkg.sv ====
`default_nettype none
`include "csr_config.svh"

package csr_pkg;

    typedef logic [`XLEN-1:0]       xlen_t;
    typedef logic [`CSR_ADDR_W-1:0] csr_addr_t;
    typedef logic [`XLEN-2:0]       cause_code_t;   // mcause without the interrupt flag

    // encoding follows funct3[1:0] of the csr instructions
    typedef enum logic [1:0]
    {
        NONE = 2'd0,
        RW   = 2'd1,
        RS   = 2'd2,
        RC   = 2'd3
    } csr_op_t;

    typedef enum logic [1:0]
    {
        WR_NONE = 2'd0,
        WR_CSR  = 2'd1,   // csr instruction update
        WR_TRAP = 2'd2,   // trap entry with epc cause tval and status stack
        WR_MRET = 2'd3    // status restore
    } wr_kind_t;

    typedef enum logic
    {
        TRAP_IDLE  = 1'b0,
        TRAP_ENTRY = 1'b1
    } trap_state_t;

endpackage

`default_nettype wire

// ==== common/csr_wr_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface csr_wr_if;
    import csr_pkg::*;

    wr_kind_t    kind;
    csr_addr_t   addr;
    xlen_t       data;
    logic        is_irq;   // trap is an interrupt
    cause_code_t cause;
    xlen_t       epc;
    xlen_t       tval;

    modport source
    (
        output kind,
        output addr,
        output data,
        output is_irq,
        output cause,
        output epc,
        output tval
    );

    modport sink
    (
        input kind,
        input addr,
        input data,
        input is_irq,
        input cause,
        input epc,
        input tval
    );

endinterface

`default_nettype wire

// ==== design/csr_instr_write.sv ====
`timescale 1ns/1ns
`default_nettype none

module csr_instr_write (
    input  logic               i_csr_unit_csr_wen,
    input  csr_pkg::csr_op_t   i_op,
    input  csr_pkg::xlen_t     i_src,
    input  csr_pkg::csr_addr_t i_addr,
    input  csr_pkg::xlen_t     i_rdata,
    csr_wr_if.source           o_wr
);
    import csr_pkg::*;

    xlen_t new_value;

    // read-modify on the current csr value
    always_comb
    begin
        case (i_op)
            RW:      new_value = i_src;
            RS:      new_value = i_rdata | i_src;
            RC:      new_value = i_rdata & ~i_src;
            default: new_value = i_rdata;
        endcase
    end

    assign o_wr.kind   = (i_csr_unit_csr_wen && (i_op != NONE)) ? WR_CSR : WR_NONE;
    assign o_wr.addr   = i_addr;
    assign o_wr.data   = new_value;
    assign o_wr.is_irq = 1'b0;   // trap fields unused here
    assign o_wr.cause  = '0;
    assign o_wr.epc    = '0;
    assign o_wr.tval   = '0;

endmodule

`default_nettype wire

// ==== trap_ctrl/trap_controller.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "csr_config.svh"

module trap_controller (
    input  logic           i_csr_unit_clk,
    input  logic           i_csr_unit_rst_n,
    input  csr_pkg::xlen_t i_pc,
    input  csr_pkg::xlen_t i_fault_addr,
    input  logic           i_illegal_instr,
    input  logic           i_instr_addr_misaligned,
    input  logic           i_ecall,
    input  logic           i_ebreak,
    input  logic           i_sw_access_fault,
    input  logic           i_lw_access_fault,
    input  logic           i_mret,
    input  logic           i_mstatus_mie,
    input  logic           i_mie_meie,
    input  logic           i_mie_mtie,
    input  logic           i_mip_meip,
    input  logic           i_mip_mtip,
    input  csr_pkg::xlen_t i_mtvec,
    input  csr_pkg::xlen_t i_mepc,
    csr_wr_if.source       o_wr,
    output csr_pkg::xlen_t o_irq_handler,
    output csr_pkg::xlen_t o_rtrn_addr,
    output logic           o_addr_ctrl,
    output logic           o_trap_redirect,
    output logic           o_ack
);
    import csr_pkg::*;

    trap_state_t state;
    logic        take;
    logic        sel_irq;
    cause_code_t sel_cause;
    xlen_t       sel_tval;
    logic        entry_irq;
    cause_code_t entry_cause;
    xlen_t       vec_base;

    // interrupts first, then exceptions in fixed order
    always_comb
    begin
        take      = 1'b1;
        sel_irq   = 1'b0;
        sel_cause = '0;
        sel_tval  = '0;
        if (i_mstatus_mie && i_mie_meie && i_mip_meip)
        begin
            sel_irq   = 1'b1;
            sel_cause = `CAUSE_M_EXTERNAL;
        end
        else if (i_mstatus_mie && i_mie_mtie && i_mip_mtip)
        begin
            sel_irq   = 1'b1;
            sel_cause = `CAUSE_M_TIMER;
        end
        else if (i_illegal_instr)
            sel_cause = `CAUSE_ILLEGAL_INSTR;
        else if (i_instr_addr_misaligned)
            sel_cause = `CAUSE_MISALIGNED;
        else if (i_ecall)
            sel_cause = `CAUSE_ECALL;
        else if (i_ebreak)
            sel_cause = `CAUSE_EBREAK;
        else if (i_sw_access_fault)
        begin
            sel_cause = `CAUSE_SW_FAULT;
            sel_tval  = i_fault_addr;
        end
        else if (i_lw_access_fault)
        begin
            sel_cause = `CAUSE_LW_FAULT;
            sel_tval  = i_fault_addr;
        end
        else
            take = 1'b0;
        if (state != TRAP_IDLE)
            take = 1'b0;   // nothing new while entering
    end

    always_comb
    begin
        o_wr.kind   = WR_NONE;
        o_wr.addr   = '0;
        o_wr.data   = '0;
        o_wr.is_irq = sel_irq;
        o_wr.cause  = sel_cause;
        o_wr.epc    = i_pc;
        o_wr.tval   = sel_tval;
        if (take)
            o_wr.kind = WR_TRAP;
        else if (i_mret)
            o_wr.kind = WR_MRET;
    end

    always_ff @(posedge i_csr_unit_clk or negedge i_csr_unit_rst_n)
    begin
        if (!i_csr_unit_rst_n)
        begin
            state       <= TRAP_IDLE;
            entry_irq   <= 1'b0;
            entry_cause <= '0;
        end
        else
        begin
            case (state)
                TRAP_IDLE:
                begin
                    if (take)
                    begin
                        state       <= TRAP_ENTRY;
                        entry_irq   <= sel_irq;
                        entry_cause <= sel_cause;
                    end
                end
                TRAP_ENTRY: state <= TRAP_IDLE;
            endcase
        end
    end

    assign vec_base = {i_mtvec[`XLEN-1:2], 2'b00};

    // vectored mode offsets interrupts only
    assign o_irq_handler   = !i_mtvec[0] ? i_mtvec :
                             entry_irq ? vec_base + {entry_cause[`XLEN-3:0], 2'b00} : vec_base;
    assign o_trap_redirect = (state == TRAP_ENTRY);
    assign o_ack           = o_trap_redirect && entry_irq && (entry_cause == `CAUSE_M_EXTERNAL);
    assign o_addr_ctrl     = i_mret;
    assign o_rtrn_addr     = i_mepc;

    a_redirect_single: assert property (
        @(posedge i_csr_unit_clk) disable iff (!i_csr_unit_rst_n)
        o_trap_redirect |=> !o_trap_redirect
    );

endmodule

`default_nettype wire

// ==== design/csr_write_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module csr_write_arbiter (
    input  logic     i_csr_unit_clk,
    input  logic     i_csr_unit_rst_n,
    csr_wr_if.sink   i_trap,
    csr_wr_if.sink   i_instr,
    csr_wr_if.source o_grant
);
    import csr_pkg::*;

    logic trap_sel;

    // trap and mret always win, instruction write dropped
    assign trap_sel = (i_trap.kind != WR_NONE);

    assign o_grant.kind   = trap_sel ? i_trap.kind   : i_instr.kind;
    assign o_grant.addr   = trap_sel ? i_trap.addr   : i_instr.addr;
    assign o_grant.data   = trap_sel ? i_trap.data   : i_instr.data;
    assign o_grant.is_irq = trap_sel ? i_trap.is_irq : i_instr.is_irq;
    assign o_grant.cause  = trap_sel ? i_trap.cause  : i_instr.cause;
    assign o_grant.epc    = trap_sel ? i_trap.epc    : i_instr.epc;
    assign o_grant.tval   = trap_sel ? i_trap.tval   : i_instr.tval;

    a_no_csr_during_trap: assert property (
        @(posedge i_csr_unit_clk) disable iff (!i_csr_unit_rst_n)
        trap_sel |-> (o_grant.kind != WR_CSR)
    );

endmodule

`default_nettype wire

// ==== csr_regfile/csr_regfile.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "csr_config.svh"

module csr_regfile (
    input  logic               i_csr_unit_clk,
    input  logic               i_csr_unit_rst_n,
    csr_wr_if.sink             i_wr,
    input  logic               i_mexternal,
    input  csr_pkg::csr_addr_t i_rd_addr,
    output csr_pkg::xlen_t     o_rdata,
    output logic               o_mstatus_mie,
    output logic               o_mie_meie,
    output logic               o_mie_mtie,
    output logic               o_mip_meip,
    output logic               o_mip_mtip,
    output csr_pkg::xlen_t     o_mtvec,
    output csr_pkg::xlen_t     o_mepc
);
    import csr_pkg::*;

    logic  mstatus_mie;
    logic  mstatus_mpie;
    logic  mie_meie;
    logic  mie_mtie;
    logic  mip_meip;
    logic  mip_mtip;
    xlen_t mtvec;
    xlen_t mscratch;
    xlen_t mtimecmp;
    xlen_t mepc;
    xlen_t mcause;
    xlen_t mtval;
    xlen_t counter;
    xlen_t mstatus;
    xlen_t mie;
    xlen_t mip;

    assign mstatus = {51'b0, 2'b11, 3'b0, mstatus_mpie, 3'b0, mstatus_mie, 3'b0};   // mpp stays M
    assign mie     = {52'b0, mie_meie, 3'b0, mie_mtie, 7'b0};
    assign mip     = {52'b0, mip_meip, 3'b0, mip_mtip, 7'b0};

    always_comb
    begin
        case (i_rd_addr)
            `CSR_MSTATUS:  o_rdata = mstatus;
            `CSR_MISA:     o_rdata = `MISA_VALUE;
            `CSR_MIE:      o_rdata = mie;
            `CSR_MIP:      o_rdata = mip;
            `CSR_MTVEC:    o_rdata = mtvec;
            `CSR_MSCRATCH: o_rdata = mscratch;
            `CSR_MEPC:     o_rdata = mepc;
            `CSR_MCAUSE:   o_rdata = mcause;
            `CSR_MTVAL:    o_rdata = mtval;
            `CSR_MTIMECMP: o_rdata = mtimecmp;
            `CSR_CYCLE,
            `CSR_TIME:     o_rdata = counter;
            default:       o_rdata = '0;   // id registers and unmapped addresses
        endcase
    end

    always_ff @(posedge i_csr_unit_clk or negedge i_csr_unit_rst_n)
    begin
        if (!i_csr_unit_rst_n)
        begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mie_meie     <= 1'b0;
            mie_mtie     <= 1'b0;
            mtvec        <= '0;
            mscratch     <= '0;
            mtimecmp     <= '0;
            mepc         <= '0;
            mcause       <= '0;
            mtval        <= '0;
        end
        else
        begin
            case (i_wr.kind)
                WR_CSR:
                begin
                    case (i_wr.addr)
                        `CSR_MSTATUS:
                        begin
                            mstatus_mie  <= i_wr.data[3];
                            mstatus_mpie <= i_wr.data[7];
                        end
                        `CSR_MIE:
                        begin
                            mie_meie <= i_wr.data[11];
                            mie_mtie <= i_wr.data[7];
                        end
                        `CSR_MTVEC:    mtvec    <= i_wr.data;
                        `CSR_MSCRATCH: mscratch <= i_wr.data;
                        `CSR_MCAUSE:   mcause   <= i_wr.data;
                        `CSR_MTVAL:    mtval    <= i_wr.data;
                        `CSR_MTIMECMP: mtimecmp <= i_wr.data;
                        default:       ;   // read-only or unmapped
                    endcase
                end
                WR_TRAP:
                begin
                    mepc         <= i_wr.epc;
                    mcause       <= {i_wr.is_irq, i_wr.cause};
                    mtval        <= i_wr.tval;
                    mstatus_mpie <= mstatus_mie;
                    mstatus_mie  <= 1'b0;
                end
                WR_MRET:
                begin
                    mstatus_mie  <= mstatus_mpie;
                    mstatus_mpie <= 1'b1;
                end
                default:       ;
            endcase
        end
    end

    // free running counter and pending bits
    always_ff @(posedge i_csr_unit_clk or negedge i_csr_unit_rst_n)
    begin
        if (!i_csr_unit_rst_n)
        begin
            counter  <= '0;
            mip_meip <= 1'b0;
            mip_mtip <= 1'b0;
        end
        else
        begin
            counter  <= counter + 1'b1;
            mip_meip <= i_mexternal;
            mip_mtip <= (counter >= mtimecmp);
        end
    end

    assign o_mstatus_mie = mstatus_mie;
    assign o_mie_meie    = mie_meie;
    assign o_mie_mtie    = mie_mtie;
    assign o_mip_meip    = mip_meip;
    assign o_mip_mtip    = mip_mtip;
    assign o_mtvec       = mtvec;
    assign o_mepc        = mepc;

    a_wr_kind_known: assert property (
        @(posedge i_csr_unit_clk) disable iff (!i_csr_unit_rst_n)
        !$isunknown(i_wr.kind)
    );

endmodule

`default_nettype wire

// ==== design/csr_unit_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module csr_unit_top (
    input  logic               i_csr_unit_clk,
    input  logic               i_csr_unit_rst_n,
    input  csr_pkg::xlen_t     i_csr_unit_pc,
    input  csr_pkg::xlen_t     i_csr_unit_fault_addr,
    input  logic               i_csr_unit_mexternal,
    input  logic               i_csr_unit_csr_wen,
    input  csr_pkg::csr_op_t   i_csr_unit_op,
    input  csr_pkg::xlen_t     i_csr_unit_src,
    input  csr_pkg::csr_addr_t i_csr_unit_csr_addr,
    input  logic               i_csr_unit_mret,
    input  logic               i_csr_unit_ecall,
    input  logic               i_csr_unit_ebreak,
    input  logic               i_csr_unit_illegal_instr,
    input  logic               i_csr_unit_instr_addr_misaligned,
    input  logic               i_csr_unit_lw_access_fault,
    input  logic               i_csr_unit_sw_access_fault,
    output csr_pkg::xlen_t     o_csr_unit_csr_rdata,
    output csr_pkg::xlen_t     o_csr_unit_irq_handler,
    output csr_pkg::xlen_t     o_csr_unit_rtrn_addr,
    output logic               o_csr_unit_addr_ctrl,
    output logic               o_csr_unit_trap_redirect,
    output logic               o_csr_unit_ack
);
    import csr_pkg::*;

    logic  mstatus_mie;
    logic  mie_meie;
    logic  mie_mtie;
    logic  mip_meip;
    logic  mip_mtip;
    xlen_t mtvec;
    xlen_t mepc;

    csr_wr_if instr_wr ();
    csr_wr_if trap_wr ();
    csr_wr_if reg_wr ();   // granted request

    csr_instr_write u_instr_write (
        .i_csr_unit_csr_wen (i_csr_unit_csr_wen),
        .i_op               (i_csr_unit_op),
        .i_src              (i_csr_unit_src),
        .i_addr             (i_csr_unit_csr_addr),
        .i_rdata            (o_csr_unit_csr_rdata),
        .o_wr               (instr_wr)
    );

    trap_controller u_trap_ctrl (
        .i_csr_unit_clk          (i_csr_unit_clk),
        .i_csr_unit_rst_n        (i_csr_unit_rst_n),
        .i_pc                    (i_csr_unit_pc),
        .i_fault_addr            (i_csr_unit_fault_addr),
        .i_illegal_instr         (i_csr_unit_illegal_instr),
        .i_instr_addr_misaligned (i_csr_unit_instr_addr_misaligned),
        .i_ecall                 (i_csr_unit_ecall),
        .i_ebreak                (i_csr_unit_ebreak),
        .i_sw_access_fault       (i_csr_unit_sw_access_fault),
        .i_lw_access_fault       (i_csr_unit_lw_access_fault),
        .i_mret                  (i_csr_unit_mret),
        .i_mstatus_mie           (mstatus_mie),
        .i_mie_meie              (mie_meie),
        .i_mie_mtie              (mie_mtie),
        .i_mip_meip              (mip_meip),
        .i_mip_mtip              (mip_mtip),
        .i_mtvec                 (mtvec),
        .i_mepc                  (mepc),
        .o_wr                    (trap_wr),
        .o_irq_handler           (o_csr_unit_irq_handler),
        .o_rtrn_addr             (o_csr_unit_rtrn_addr),
        .o_addr_ctrl             (o_csr_unit_addr_ctrl),
        .o_trap_redirect         (o_csr_unit_trap_redirect),
        .o_ack                   (o_csr_unit_ack)
    );

    csr_write_arbiter u_wr_arb (
        .i_csr_unit_clk   (i_csr_unit_clk),
        .i_csr_unit_rst_n (i_csr_unit_rst_n),
        .i_trap           (trap_wr),
        .i_instr          (instr_wr),
        .o_grant          (reg_wr)
    );

    csr_regfile u_regfile (
        .i_csr_unit_clk   (i_csr_unit_clk),
        .i_csr_unit_rst_n (i_csr_unit_rst_n),
        .i_wr             (reg_wr),
        .i_mexternal      (i_csr_unit_mexternal),
        .i_rd_addr        (i_csr_unit_csr_addr),
        .o_rdata          (o_csr_unit_csr_rdata),
        .o_mstatus_mie    (mstatus_mie),
        .o_mie_meie       (mie_meie),
        .o_mie_mtie       (mie_mtie),
        .o_mip_meip       (mip_meip),
        .o_mip_mtip       (mip_mtip),
        .o_mtvec          (mtvec),
        .o_mepc           (mepc)
    );

endmodule

`default_nettype wire

// ==== dv/tb_csr_unit.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "csr_config.svh"

module tb_csr_unit;
    import csr_pkg::*;

    localparam int CLK_PERIOD = 100;

    logic      clk;
    logic      rst_n;
    xlen_t     pc;
    xlen_t     fault_addr;
    logic      mexternal;
    logic      csr_wen;
    csr_op_t   csr_op;
    xlen_t     csr_src;
    csr_addr_t csr_addr;
    logic      mret;
    logic      ecall;
    logic      ebreak;
    logic      illegal_instr;
    logic      misaligned;
    logic      lw_fault;
    logic      sw_fault;
    xlen_t     csr_rdata;
    xlen_t     irq_handler;
    xlen_t     rtrn_addr;
    logic      addr_ctrl;
    logic      trap_redirect;
    logic      ack;

    logic [63:0] kind_q[$];
    csr_addr_t   addr_q[$];
    logic [7:0]  op_q[$];
    xlen_t       data_q[$];
    xlen_t       exp_q[$];
    xlen_t       shadow [0:4095];   // expected value per csr address
    xlen_t       earlier_cycle;
    int          num_steps;

    csr_unit_top UUT (
        .i_csr_unit_clk                   (clk),
        .i_csr_unit_rst_n                 (rst_n),
        .i_csr_unit_pc                    (pc),
        .i_csr_unit_fault_addr            (fault_addr),
        .i_csr_unit_mexternal             (mexternal),
        .i_csr_unit_csr_wen               (csr_wen),
        .i_csr_unit_op                    (csr_op),
        .i_csr_unit_src                   (csr_src),
        .i_csr_unit_csr_addr              (csr_addr),
        .i_csr_unit_mret                  (mret),
        .i_csr_unit_ecall                 (ecall),
        .i_csr_unit_ebreak                (ebreak),
        .i_csr_unit_illegal_instr         (illegal_instr),
        .i_csr_unit_instr_addr_misaligned (misaligned),
        .i_csr_unit_lw_access_fault       (lw_fault),
        .i_csr_unit_sw_access_fault       (sw_fault),
        .o_csr_unit_csr_rdata             (csr_rdata),
        .o_csr_unit_irq_handler           (irq_handler),
        .o_csr_unit_rtrn_addr             (rtrn_addr),
        .o_csr_unit_addr_ctrl             (addr_ctrl),
        .o_csr_unit_trap_redirect         (trap_redirect),
        .o_csr_unit_ack                   (ack)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("ERRORS FOUND");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input xlen_t actual, input xlen_t expected);
        if (actual !== expected)
        begin
            $display("** Error at %0t ns: %s expected %h actual %h", $time, name, expected, actual);
            $display("ERRORS FOUND");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #10;   // inputs change after the edge
    endtask

    task automatic set_exceptions(input logic [5:0] mask);
        illegal_instr = mask[0];
        misaligned    = mask[1];
        ecall         = mask[2];
        ebreak        = mask[3];
        sw_fault      = mask[4];
        lw_fault      = mask[5];
    endtask

    task automatic clear_inputs();
        pc         = '0;
        fault_addr = '0;
        mexternal  = 1'b0;
        csr_wen    = 1'b0;
        csr_op     = NONE;
        csr_src    = '0;
        csr_addr   = '0;
        mret       = 1'b0;
        set_exceptions(6'b0);
    endtask

    // write replaces, set ors in, clear removes bits
    function automatic xlen_t apply_op(input xlen_t old, input logic [1:0] op, input xlen_t src);
        case (op)
            2'd1:    return src;
            2'd2:    return old | src;
            2'd3:    return old & ~src;
            default: return old;
        endcase
    endfunction

    function automatic xlen_t handler_addr(input xlen_t tvec, input logic is_irq,
                                           input cause_code_t cause);
        xlen_t base;
        base = tvec & ~64'h3;
        if (!tvec[0])
            return tvec;
        else if (is_irq)
            return base + (xlen_t'(cause) * 4);
        else
            return base;
    endfunction

    task automatic wait_redirect(input int max_cycles);
        int n;
        logic seen;
        seen = 1'b0;
        for (n = 0; n < max_cycles && !seen; n++)
        begin
            next_cycle();
            #5;
            seen = trap_redirect;
        end
        if (!seen)
            fail_run("no trap redirect seen while waiting for an interrupt");
    endtask

    task automatic run_step(input int idx);
        logic [63:0] kind;
        csr_addr_t   addr;
        logic [7:0]  op;
        xlen_t       data;
        xlen_t       exp_v;
        cause_code_t cause;
        kind  = kind_q[idx];
        addr  = addr_q[idx];
        op    = op_q[idx];
        data  = data_q[idx];
        exp_v = exp_q[idx];
        case (kind)
            "rd", "rdm":
            begin
                next_cycle();
                csr_addr = addr;
                #5;
                if (kind == "rd")
                    check_value("o_csr_unit_csr_rdata", csr_rdata, exp_v);
                else
                    check_value("o_csr_unit_csr_rdata", csr_rdata, shadow[addr]);
            end
            "op", "rop":
            begin
                next_cycle();
                if (kind == "rop")
                    data = ({$urandom, $urandom} & ~64'h3) | (data & 64'h3);
                csr_wen  = 1'b1;
                csr_op   = csr_op_t'(op[1:0]);
                csr_addr = addr;
                csr_src  = data;
                shadow[addr] = apply_op(shadow[addr], op[1:0], data);
                next_cycle();
                csr_wen = 1'b0;
                csr_op  = NONE;
            end
            "exc", "excw":
            begin
                next_cycle();
                set_exceptions(op[5:0]);
                pc         = data;
                fault_addr = exp_v;
                if (kind == "excw")
                begin
                    csr_wen  = 1'b1;   // must lose against the trap
                    csr_op   = RW;
                    csr_addr = addr;
                    csr_src  = exp_v;
                end
                next_cycle();
                set_exceptions(6'b0);
                csr_wen = 1'b0;
                csr_op  = NONE;
                #5;
                check_value("o_csr_unit_trap_redirect", xlen_t'(trap_redirect), 64'd1);
                check_value("o_csr_unit_ack", xlen_t'(ack), 64'd0);
                check_value("o_csr_unit_irq_handler", irq_handler,
                            handler_addr(shadow[`CSR_MTVEC], 1'b0, '0));
                next_cycle();
                #5;
                check_value("o_csr_unit_trap_redirect", xlen_t'(trap_redirect), 64'd0);
            end
            "irq":
            begin
                next_cycle();
                pc    = data;
                cause = op[0] ? `CAUSE_M_TIMER : `CAUSE_M_EXTERNAL;
                if (!op[0])
                    mexternal = 1'b1;
                wait_redirect(32);
                check_value("o_csr_unit_ack", xlen_t'(ack), exp_v);
                check_value("o_csr_unit_irq_handler", irq_handler,
                            handler_addr(shadow[`CSR_MTVEC], 1'b1, cause));
                next_cycle();
                mexternal = 1'b0;
            end
            "mret":
            begin
                next_cycle();
                mret = 1'b1;
                #5;
                check_value("o_csr_unit_addr_ctrl", xlen_t'(addr_ctrl), 64'd1);
                check_value("o_csr_unit_rtrn_addr", rtrn_addr, exp_v);
                next_cycle();
                mret = 1'b0;
            end
            "tcmp":
            begin
                next_cycle();
                csr_addr = `CSR_CYCLE;
                #5;
                earlier_cycle = csr_rdata;
                next_cycle();
                csr_wen  = 1'b1;
                csr_op   = RW;
                csr_addr = addr;
                csr_src  = earlier_cycle + data;   // compare point a few cycles ahead
                shadow[addr] = earlier_cycle + data;
                next_cycle();
                csr_wen = 1'b0;
                csr_op  = NONE;
            end
            "cyc":
            begin
                next_cycle();
                csr_addr = `CSR_CYCLE;
                #5;
                check_value("o_csr_unit_csr_rdata > earlier cycle",
                            xlen_t'(csr_rdata > earlier_cycle), 64'd1);
            end
            default: fail_run("unknown step kind in the stimulus file");
        endcase
    endtask

    task automatic load_steps();
        int          fd;
        int          n;
        string       line;
        logic [63:0] kind;
        logic [63:0] addr;
        logic [63:0] op;
        xlen_t       data;
        xlen_t       exp_v;
        fd = $fopen("dv/csr_unit_stim.txt", "r");
        if (fd == 0)
            fail_run("could not open the stimulus file dv/csr_unit_stim.txt");
        else
        begin
            while (!$feof(fd))
            begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line[0] != "#")
                begin
                    n = $sscanf(line, "%s %h %h %h %h", kind, addr, op, data, exp_v);
                    if (n == 5)
                    begin
                        kind_q.push_back(kind);
                        addr_q.push_back(addr[11:0]);
                        op_q.push_back(op[7:0]);
                        data_q.push_back(data);
                        exp_q.push_back(exp_v);
                    end
                    else
                        fail_run("a line of the stimulus file does not hold five fields");
                end
            end
            $fclose(fd);
            num_steps = kind_q.size();
        end
    endtask

    // watchdog sized from the number of steps
    initial
    begin
        wait (num_steps > 0);
        #(num_steps * 20 * CLK_PERIOD);
        $display("timeout, the stimulus steps did not finish in time");
        $display("ERRORS FOUND");
        $fatal(1, "watchdog expired");
    end

    initial
    begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        num_steps = 0;
        clear_inputs();
        void'($urandom(40));
        for (int a = 0; a < 4096; a++)
            shadow[a] = '0;   // reset values
        load_steps();
        if (num_steps == 0)
            fail_run("the stimulus file holds no steps");
        repeat (5) @(posedge clk);
        #10;
        rst_n = 1'b1;
        #5;
        check_value("o_csr_unit_trap_redirect", xlen_t'(trap_redirect), 64'd0);
        check_value("o_csr_unit_ack", xlen_t'(ack), 64'd0);
        check_value("o_csr_unit_addr_ctrl", xlen_t'(addr_ctrl), 64'd0);
        for (int i = 0; i < num_steps; i++)
            run_step(i);
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/csr_unit_stim.txt ====
# kind addr op data expect, all numbers hex
# op holds the exception mask for exc/excw (bit0 illegal .. bit5 load fault), the source for irq
rd   305 0 0        0
rd   340 0 0        0
rd   301 0 0        8000000000101105
rd   7c0 0 0        0
rop  340 1 0        0
rdm  340 0 0        0
op   340 2 f0f0     0
rdm  340 0 0        0
op   340 3 ff00ff   0
rdm  340 0 0        0
op   301 1 ffff     0
rd   301 0 0        8000000000101105
rop  305 1 0        0
rdm  305 0 0        0
op   300 2 8        0
rd   300 0 0        1808
exc  0   20 80001000 dead0040
rd   341 0 0        80001000
rd   342 0 0        5
rd   343 0 0        dead0040
rd   300 0 0        1880
excw 340 5 80002000 1234
rd   342 0 0        2
rd   343 0 0        0
rdm  340 0 0        0
rop  305 1 1        0
rdm  305 0 0        0
op   304 2 800      0
op   300 2 8        0
irq  0   0 80004000 1
rd   342 0 0        800000000000000b
rd   341 0 0        80004000
rd   300 0 0        1880
mret 0   0 0        80004000
rd   300 0 0        1888
tcmp bbf 0 10       0
op   304 2 80       0
irq  0   1 80005000 0
rd   342 0 0        8000000000000007
rd   341 0 0        80005000
cyc  c00 0 0        0

// ==== tb.f ====
+incdir+common
common/csr_pkg.sv
common/csr_wr_if.sv
design/csr_instr_write.sv
trap_ctrl/trap_controller.sv
design/csr_write_arbiter.sv
csr_regfile/csr_regfile.sv
design/csr_unit_top.sv
dv/tb_csr_unit.sv

// ==== Makefile ====
TOP := tb_csr_unit

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -Wno-fatal -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
